// ==== source/dram_params.svh ====
// Width and depth macros of the DRAM wrapper
// SoC side, memory side and memory model depth

`ifndef DRAM_PARAMS_SVH
`define DRAM_PARAMS_SVH

// SoC-side request fields
`define DRAM_SOC_ID_WIDTH    6
`define DRAM_SOC_ADDR_WIDTH  32

// Memory-side request fields
`define DRAM_MEM_ID_WIDTH    4
`define DRAM_MEM_ADDR_WIDTH  12

// Data path, single beat
`define DRAM_DATA_WIDTH      64
`define DRAM_STRB_WIDTH      8

// Behavioral memory depth in data words
`define DRAM_MEM_WORDS       512

`endif

// ==== source/dram_soc_pkg.sv ====
// SoC-side field types of the DRAM wrapper
// Full request ID and address, data, strobe and response

`include "dram_params.svh"

package dram_soc_pkg;

  //////////////////////////////////////////////////
  // Request fields
  //////////////////////////////////////////////////

  // Full ID as issued by the SoC
  typedef logic [`DRAM_SOC_ID_WIDTH-1:0]   soc_id_t;

  // Full byte address before truncation
  typedef logic [`DRAM_SOC_ADDR_WIDTH-1:0] soc_addr_t;

  //////////////////////////////////////////////////
  // Data and response fields
  //////////////////////////////////////////////////

  // Single-beat write and read data
  typedef logic [`DRAM_DATA_WIDTH-1:0]     soc_data_t;

  // One strobe bit per data byte
  typedef logic [`DRAM_STRB_WIDTH-1:0]     soc_strb_t;

  // AXI response code
  typedef logic [1:0]                      soc_resp_t;

endpackage

// ==== source/dram_mem_pkg.sv ====
// Memory-side channel types of the DRAM wrapper
// Narrowed ID and address, and the five channel payloads

`include "dram_params.svh"

package dram_mem_pkg;

  typedef logic [`DRAM_MEM_ID_WIDTH-1:0]   mem_id_t;
  typedef logic [`DRAM_MEM_ADDR_WIDTH-1:0] mem_addr_t;
  typedef logic [`DRAM_DATA_WIDTH-1:0]     mem_data_t;
  typedef logic [`DRAM_STRB_WIDTH-1:0]     mem_strb_t;
  typedef logic [1:0]                      mem_resp_t;

  // Only response the model ever returns
  localparam mem_resp_t resp_okay = 2'b00;

  //////////////////////////////////////////////////
  // Channel payloads
  //////////////////////////////////////////////////

  typedef struct packed {mem_id_t id; mem_addr_t addr;} mem_aw_t;
  typedef struct packed {mem_id_t id; mem_addr_t addr;} mem_ar_t;
  typedef struct packed {mem_data_t data; mem_strb_t strb;} mem_w_t;
  typedef struct packed {mem_id_t id; mem_resp_t resp;} mem_b_t;

  typedef struct packed {
    mem_id_t   id;
    mem_data_t data;
    mem_resp_t resp;
  } mem_r_t;

endpackage

// ==== source/dram_axi_if.sv ====
// Memory-side AXI bus with five single-beat channels
// Master and slave modports

`timescale 1ns/10ps

interface dram_axi_if;

  // Write address, data and response
  logic                  aw_valid;
  logic                  aw_ready;
  dram_mem_pkg::mem_aw_t aw;
  logic                  w_valid;
  logic                  w_ready;
  dram_mem_pkg::mem_w_t  w;
  logic                  b_valid;
  logic                  b_ready;
  dram_mem_pkg::mem_b_t  b;

  // Read address and data
  logic                  ar_valid;
  logic                  ar_ready;
  dram_mem_pkg::mem_ar_t ar;
  logic                  r_valid;
  logic                  r_ready;
  dram_mem_pkg::mem_r_t  r;

  // Request side, drives aw, w and ar
  modport mst (
    output aw_valid, aw, w_valid, w, ar_valid, ar, b_ready, r_ready,
    input  aw_ready, w_ready, ar_ready, b_valid, b, r_valid, r
  );

  // Memory side, answers on b and r
  modport slv (
    input  aw_valid, aw, w_valid, w, ar_valid, ar, b_ready, r_ready,
    output aw_ready, w_ready, ar_ready, b_valid, b, r_valid, r
  );

endinterface

// ==== source/dram_port_adapter.sv ====
// SoC port adapter of the DRAM wrapper
// ID narrowing and restore, address truncation, one read and one write in flight

`timescale 1ns/10ps

`include "dram_params.svh"

module dram_port_adapter (
  input  logic                    soc_clk_i,
  input  logic                    arst_n_i,
  // Write address
  input  logic                    soc_aw_valid_i,
  input  dram_soc_pkg::soc_id_t   soc_aw_id_i,
  input  dram_soc_pkg::soc_addr_t soc_aw_addr_i,
  output logic                    soc_aw_ready_o,
  // Write data
  input  logic                    soc_w_valid_i,
  input  dram_soc_pkg::soc_data_t soc_w_data_i,
  input  dram_soc_pkg::soc_strb_t soc_w_strb_i,
  output logic                    soc_w_ready_o,
  // Write response
  output logic                    soc_b_valid_o,
  output dram_soc_pkg::soc_id_t   soc_b_id_o,
  output dram_soc_pkg::soc_resp_t soc_b_resp_o,
  input  logic                    soc_b_ready_i,
  // Read address
  input  logic                    soc_ar_valid_i,
  input  dram_soc_pkg::soc_id_t   soc_ar_id_i,
  input  dram_soc_pkg::soc_addr_t soc_ar_addr_i,
  output logic                    soc_ar_ready_o,
  // Read data
  output logic                    soc_r_valid_o,
  output dram_soc_pkg::soc_id_t   soc_r_id_o,
  output dram_soc_pkg::soc_data_t soc_r_data_o,
  output dram_soc_pkg::soc_resp_t soc_r_resp_o,
  input  logic                    soc_r_ready_i,
  // Memory-side bus
  dram_axi_if.mst                 bus
);

  // Set once the request half went out, cleared by its response
  logic aw_pend_q;
  logic w_pend_q;
  logic rd_pend_q;

  // Full IDs waiting for their response
  dram_soc_pkg::soc_id_t b_id_q;
  dram_soc_pkg::soc_id_t r_id_q;

  logic aw_fire;
  logic w_fire;
  logic b_fire;
  logic ar_fire;
  logic r_fire;

  //////////////////////////////////////////////////
  // Request path
  //////////////////////////////////////////////////

  // Low ID bits and low address bits go to the memory
  assign bus.aw_valid = soc_aw_valid_i & ~aw_pend_q;
  assign bus.aw = '{id: soc_aw_id_i[`DRAM_MEM_ID_WIDTH-1:0],
                    addr: soc_aw_addr_i[`DRAM_MEM_ADDR_WIDTH-1:0]};
  assign soc_aw_ready_o = bus.aw_ready & ~aw_pend_q;

  assign bus.w_valid = soc_w_valid_i & ~w_pend_q;
  assign bus.w = '{data: soc_w_data_i, strb: soc_w_strb_i};
  assign soc_w_ready_o = bus.w_ready & ~w_pend_q;

  assign bus.ar_valid = soc_ar_valid_i & ~rd_pend_q;
  assign bus.ar = '{id: soc_ar_id_i[`DRAM_MEM_ID_WIDTH-1:0],
                    addr: soc_ar_addr_i[`DRAM_MEM_ADDR_WIDTH-1:0]};
  assign soc_ar_ready_o = bus.ar_ready & ~rd_pend_q;

  //////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////

  // Stored full ID replaces the narrowed one
  assign soc_b_valid_o = bus.b_valid;
  assign soc_b_id_o    = b_id_q;
  assign soc_b_resp_o  = bus.b.resp;
  assign bus.b_ready   = soc_b_ready_i;

  assign soc_r_valid_o = bus.r_valid;
  assign soc_r_id_o    = r_id_q;
  assign soc_r_data_o  = bus.r.data;
  assign soc_r_resp_o  = bus.r.resp;
  assign bus.r_ready   = soc_r_ready_i;

  assign aw_fire = bus.aw_valid & bus.aw_ready;
  assign w_fire  = bus.w_valid & bus.w_ready;
  assign b_fire  = bus.b_valid & bus.b_ready;
  assign ar_fire = bus.ar_valid & bus.ar_ready;
  assign r_fire  = bus.r_valid & bus.r_ready;

  // Outstanding flags and ID capture
  always_ff @(posedge soc_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
      rd_pend_q <= 1'b0;
      b_id_q    <= '0;
      r_id_q    <= '0;
    end
    else
    begin
      // b only arrives once both halves are in, so no overlap with a new aw
      if (b_fire)
      begin
        aw_pend_q <= 1'b0;
        w_pend_q  <= 1'b0;
      end
      else
      begin
        if (aw_fire)
          aw_pend_q <= 1'b1;
        if (w_fire)
          w_pend_q <= 1'b1;
      end
      if (aw_fire)
        b_id_q <= soc_aw_id_i;
      if (ar_fire)
      begin
        rd_pend_q <= 1'b1;
        r_id_q    <= soc_ar_id_i;
      end
      else if (r_fire)
        rd_pend_q <= 1'b0;
    end
  end

endmodule

// ==== source/dram_spill_reg.sv ====
// Two-slot spill register for one valid/ready channel
// Registered ready, full throughput, payload given as a type

`timescale 1ns/10ps

module dram_spill_reg #(
  parameter type payload_t = logic
) (
  input  logic     soc_clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  // Slot a takes new items, slot b catches them when the output stalls
  logic     a_full_q, b_full_q;
  payload_t a_data_q, b_data_q;
  logic     a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = valid_i & ready_o;
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge soc_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end
    else
    begin
      a_full_q <= a_fill | (a_full_q & ~a_drain);
      b_full_q <= b_fill | (b_full_q & ~b_drain);
    end
  end

  always_ff @(posedge soc_clk_i)
  begin
    if (a_fill)
      a_data_q <= data_i;
    if (b_fill)
      b_data_q <= a_data_q;
  end

  // Older item sits in b whenever b is full
  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

// ==== source/dram_mem_model.sv ====
// Behavioral single-beat DRAM behind the memory-side bus
// Strobed writes, word reads, responses held until accepted

`timescale 1ns/10ps

`include "dram_params.svh"

module dram_mem_model (
  input  logic    soc_clk_i,
  input  logic    arst_n_i,
  dram_axi_if.slv bus
);

  // Word index is address bits 11 to 3
  localparam int unsigned word_lsb  = $clog2(`DRAM_STRB_WIDTH);
  localparam int unsigned word_bits = $clog2(`DRAM_MEM_WORDS);

  // Unwritten bytes read as zero
  dram_mem_pkg::mem_data_t mem [`DRAM_MEM_WORDS] = '{default: '0};

  logic [word_bits-1:0]    wr_idx, rd_idx;
  logic                    wr_fire, ar_fire;
  logic                    b_valid_q, r_valid_q;
  dram_mem_pkg::mem_id_t   b_id_q, r_id_q;
  dram_mem_pkg::mem_data_t r_data_q;

  assign wr_idx = bus.aw.addr[word_lsb +: word_bits];
  assign rd_idx = bus.ar.addr[word_lsb +: word_bits];

  // aw and w are taken together, never while a b is still waiting
  assign wr_fire      = bus.aw_valid & bus.w_valid & ~b_valid_q;
  assign bus.aw_ready = bus.w_valid & ~b_valid_q;
  assign bus.w_ready  = bus.aw_valid & ~b_valid_q;
  assign ar_fire      = bus.ar_valid & ~r_valid_q;
  assign bus.ar_ready = ~r_valid_q;

  always_ff @(posedge soc_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end
    else
    begin
      if (wr_fire)
        b_valid_q <= 1'b1;
      else if (bus.b_ready)
        b_valid_q <= 1'b0;
      if (ar_fire)
        r_valid_q <= 1'b1;
      else if (bus.r_ready)
        r_valid_q <= 1'b0;
    end
  end

  // Storage and response payload
  always_ff @(posedge soc_clk_i)
  begin
    if (wr_fire)
    begin
      b_id_q <= bus.aw.id;
      for (int i = 0; i < `DRAM_STRB_WIDTH; i++)
        if (bus.w.strb[i])
          mem[wr_idx][8*i +: 8] <= bus.w.data[8*i +: 8];
    end
    if (ar_fire)
    begin
      r_id_q   <= bus.ar.id;
      r_data_q <= mem[rd_idx];
    end
  end

  assign bus.b_valid = b_valid_q;
  assign bus.b = '{id: b_id_q, resp: dram_mem_pkg::resp_okay};
  assign bus.r_valid = r_valid_q;
  assign bus.r = '{id: r_id_q, data: r_data_q, resp: dram_mem_pkg::resp_okay};

endmodule

// ==== source/dram_wrapper.sv ====
// DRAM wrapper top level
// Port adapter, spill registers on all five channels, behavioral memory

`timescale 1ns/10ps

`include "dram_params.svh"

module dram_wrapper (
  input  logic                    soc_clk_i,
  input  logic                    arst_n_i,
  input  logic                    soc_aw_valid_i,
  input  dram_soc_pkg::soc_id_t   soc_aw_id_i,
  input  dram_soc_pkg::soc_addr_t soc_aw_addr_i,
  output logic                    soc_aw_ready_o,
  input  logic                    soc_w_valid_i,
  input  dram_soc_pkg::soc_data_t soc_w_data_i,
  input  dram_soc_pkg::soc_strb_t soc_w_strb_i,
  output logic                    soc_w_ready_o,
  output logic                    soc_b_valid_o,
  output dram_soc_pkg::soc_id_t   soc_b_id_o,
  output dram_soc_pkg::soc_resp_t soc_b_resp_o,
  input  logic                    soc_b_ready_i,
  input  logic                    soc_ar_valid_i,
  input  dram_soc_pkg::soc_id_t   soc_ar_id_i,
  input  dram_soc_pkg::soc_addr_t soc_ar_addr_i,
  output logic                    soc_ar_ready_o,
  output logic                    soc_r_valid_o,
  output dram_soc_pkg::soc_id_t   soc_r_id_o,
  output dram_soc_pkg::soc_data_t soc_r_data_o,
  output dram_soc_pkg::soc_resp_t soc_r_resp_o,
  input  logic                    soc_r_ready_i
);

  dram_axi_if adapter_bus ();
  dram_axi_if mem_bus ();

  //////////////////////////////////////////////////
  // SoC side
  //////////////////////////////////////////////////

  dram_port_adapter i_adapter (
    .bus (adapter_bus.mst),
    .*
  );

  //////////////////////////////////////////////////
  // Spill registers, requests down and responses up
  //////////////////////////////////////////////////

  dram_spill_reg #(.payload_t(dram_mem_pkg::mem_aw_t)) i_spill_aw (
    .soc_clk_i, .arst_n_i,
    .valid_i (adapter_bus.aw_valid), .ready_o (adapter_bus.aw_ready),
    .data_i  (adapter_bus.aw),
    .valid_o (mem_bus.aw_valid), .ready_i (mem_bus.aw_ready), .data_o (mem_bus.aw)
  );

  dram_spill_reg #(.payload_t(dram_mem_pkg::mem_w_t)) i_spill_w (
    .soc_clk_i, .arst_n_i,
    .valid_i (adapter_bus.w_valid), .ready_o (adapter_bus.w_ready),
    .data_i  (adapter_bus.w),
    .valid_o (mem_bus.w_valid), .ready_i (mem_bus.w_ready), .data_o (mem_bus.w)
  );

  dram_spill_reg #(.payload_t(dram_mem_pkg::mem_ar_t)) i_spill_ar (
    .soc_clk_i, .arst_n_i,
    .valid_i (adapter_bus.ar_valid), .ready_o (adapter_bus.ar_ready),
    .data_i  (adapter_bus.ar),
    .valid_o (mem_bus.ar_valid), .ready_i (mem_bus.ar_ready), .data_o (mem_bus.ar)
  );

  dram_spill_reg #(.payload_t(dram_mem_pkg::mem_b_t)) i_spill_b (
    .soc_clk_i, .arst_n_i,
    .valid_i (mem_bus.b_valid), .ready_o (mem_bus.b_ready), .data_i (mem_bus.b),
    .valid_o (adapter_bus.b_valid), .ready_i (adapter_bus.b_ready),
    .data_o  (adapter_bus.b)
  );

  dram_spill_reg #(.payload_t(dram_mem_pkg::mem_r_t)) i_spill_r (
    .soc_clk_i, .arst_n_i,
    .valid_i (mem_bus.r_valid), .ready_o (mem_bus.r_ready), .data_i (mem_bus.r),
    .valid_o (adapter_bus.r_valid), .ready_i (adapter_bus.r_ready),
    .data_o  (adapter_bus.r)
  );

  // Stand-in for the vendor controller
  dram_mem_model i_mem (
    .soc_clk_i,
    .arst_n_i,
    .bus (mem_bus.slv)
  );

endmodule

// ==== testbench/tb_dram_tasks.svh ====
// Transaction tasks of the DRAM wrapper testbench
// Request drive, acceptance and response waits, each with a timeout

`ifndef TB_DRAM_TASKS_SVH
`define TB_DRAM_TASKS_SVH

task automatic idle_cycles(input int n);
  for (int k = 0; k < n; k++)
    @(negedge soc_clk_i);
endtask

//////////////////////////////////////////////////
// Write side
//////////////////////////////////////////////////

// Expected ID and shadow contents are updated as the request goes out
task automatic drive_write(input dram_soc_pkg::soc_id_t id, input dram_soc_pkg::soc_addr_t addr,
                           input dram_soc_pkg::soc_data_t data,
                           input dram_soc_pkg::soc_strb_t strb);
  exp_b_id = id;
  merge_shadow(addr, data, strb);
  req_sent = 1'b1;
  soc_aw_id_i = id;
  soc_aw_addr_i = addr;
  soc_aw_valid_i = 1'b1;
  soc_w_data_i = data;
  soc_w_strb_i = strb;
  soc_w_valid_i = 1'b1;
endtask

// Each valid drops once its own handshake was counted
task automatic wait_write_accept(input int aw_target, input int w_target);
  int n;
  n = 0;
  while ((soc_aw_valid_i || soc_w_valid_i) && n < wait_limit)
  begin
    @(negedge soc_clk_i);
    n++;
    if (aw_cnt >= aw_target)
      soc_aw_valid_i = 1'b0;
    if (w_cnt >= w_target)
      soc_w_valid_i = 1'b0;
  end
  if (soc_aw_valid_i || soc_w_valid_i)
    abort_on_timeout("write address and data acceptance");
endtask

task automatic collect_write_resp();
  int start;
  int n;
  start = b_cnt;
  n = 0;
  soc_b_ready_i = 1'b1;
  while (b_cnt == start && n < wait_limit)
  begin
    @(negedge soc_clk_i);
    n++;
  end
  soc_b_ready_i = 1'b0;
  if (b_cnt == start)
    abort_on_timeout("write response");
endtask

task automatic write_word(input dram_soc_pkg::soc_id_t id, input dram_soc_pkg::soc_addr_t addr,
                          input dram_soc_pkg::soc_data_t data,
                          input dram_soc_pkg::soc_strb_t strb);
  int aw_target;
  int w_target;
  aw_target = aw_cnt + 1;
  w_target = w_cnt + 1;
  drive_write(id, addr, data, strb);
  wait_write_accept(aw_target, w_target);
  collect_write_resp();
endtask

//////////////////////////////////////////////////
// Read side
//////////////////////////////////////////////////

task automatic drive_read(input dram_soc_pkg::soc_id_t id, input dram_soc_pkg::soc_addr_t addr);
  exp_r_id = id;
  exp_r_data = shadow[word_index(addr)];
  req_sent = 1'b1;
  soc_ar_id_i = id;
  soc_ar_addr_i = addr;
  soc_ar_valid_i = 1'b1;
endtask

task automatic wait_read_accept(input int ar_target);
  int n;
  n = 0;
  while (soc_ar_valid_i && n < wait_limit)
  begin
    @(negedge soc_clk_i);
    n++;
    if (ar_cnt >= ar_target)
      soc_ar_valid_i = 1'b0;
  end
  if (soc_ar_valid_i)
    abort_on_timeout("read address acceptance");
endtask

task automatic collect_read_resp();
  int start;
  int n;
  start = r_cnt;
  n = 0;
  soc_r_ready_i = 1'b1;
  while (r_cnt == start && n < wait_limit)
  begin
    @(negedge soc_clk_i);
    n++;
  end
  soc_r_ready_i = 1'b0;
  if (r_cnt == start)
    abort_on_timeout("read data");
endtask

task automatic read_word(input dram_soc_pkg::soc_id_t id, input dram_soc_pkg::soc_addr_t addr);
  int ar_target;
  ar_target = ar_cnt + 1;
  drive_read(id, addr);
  wait_read_accept(ar_target);
  collect_read_resp();
endtask

`endif

// ==== testbench/tb_dram_wrapper.sv ====
// Testbench of the DRAM wrapper
// Clock, reset, DUT, handshake counters, assertions and test sequence

`timescale 1ns/10ps

`include "dram_params.svh"

module tb_dram_wrapper;

  localparam int          wait_limit    = 100;
  localparam logic [1:0]  resp_okay_exp = 2'b00;

  logic                    soc_clk_i;
  logic                    arst_n_i;
  logic                    soc_aw_valid_i;
  dram_soc_pkg::soc_id_t   soc_aw_id_i;
  dram_soc_pkg::soc_addr_t soc_aw_addr_i;
  logic                    soc_aw_ready_o;
  logic                    soc_w_valid_i;
  dram_soc_pkg::soc_data_t soc_w_data_i;
  dram_soc_pkg::soc_strb_t soc_w_strb_i;
  logic                    soc_w_ready_o;
  logic                    soc_b_valid_o;
  dram_soc_pkg::soc_id_t   soc_b_id_o;
  dram_soc_pkg::soc_resp_t soc_b_resp_o;
  logic                    soc_b_ready_i;
  logic                    soc_ar_valid_i;
  dram_soc_pkg::soc_id_t   soc_ar_id_i;
  dram_soc_pkg::soc_addr_t soc_ar_addr_i;
  logic                    soc_ar_ready_o;
  logic                    soc_r_valid_o;
  dram_soc_pkg::soc_id_t   soc_r_id_o;
  dram_soc_pkg::soc_data_t soc_r_data_o;
  dram_soc_pkg::soc_resp_t soc_r_resp_o;
  logic                    soc_r_ready_i;

  // Expected response fields and the shadow memory
  dram_soc_pkg::soc_id_t   exp_b_id;
  dram_soc_pkg::soc_id_t   exp_r_id;
  dram_soc_pkg::soc_data_t exp_r_data;
  dram_soc_pkg::soc_data_t shadow [`DRAM_MEM_WORDS];
  logic                    req_sent;

  // Handshakes seen at the top level
  int   aw_cnt;
  int   w_cnt;
  int   b_cnt;
  int   ar_cnt;
  int   r_cnt;
  logic wr_open;
  logic rd_open;

  string test_name;
  int    errors;
  int    errors_at_start;
  int    tests_run;
  int    tests_failed;

  dram_wrapper uut (.*);

  initial
  begin
    soc_clk_i = 1'b0;
    forever #20 soc_clk_i = ~soc_clk_i;
  end

  always @(posedge soc_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      aw_cnt <= 0;
      w_cnt  <= 0;
      b_cnt  <= 0;
      ar_cnt <= 0;
      r_cnt  <= 0;
    end
    else
    begin
      if (soc_aw_valid_i && soc_aw_ready_o)
        aw_cnt <= aw_cnt + 1;
      if (soc_w_valid_i && soc_w_ready_o)
        w_cnt <= w_cnt + 1;
      if (soc_b_valid_o && soc_b_ready_i)
        b_cnt <= b_cnt + 1;
      if (soc_ar_valid_i && soc_ar_ready_o)
        ar_cnt <= ar_cnt + 1;
      if (soc_r_valid_o && soc_r_ready_i)
        r_cnt <= r_cnt + 1;
    end
  end

  assign wr_open = aw_cnt > b_cnt;
  assign rd_open = ar_cnt > r_cnt;

  //////////////////////////////////////////////////
  // Reporting and reference helpers
  //////////////////////////////////////////////////

  function automatic void log_mismatch(input string what, input logic [63:0] exp,
                                       input logic [63:0] act);
    errors++;
    $display("FAILED %s %s expected %h actual %h", test_name, what, exp, act);
  endfunction

  function automatic void log_violation(input string text);
    errors++;
    $display("Error in test %s: %s", test_name, text);
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("Timeout in test %s: no %s within %0d cycles", test_name, what, wait_limit);
    $display("Verification failed");
    $finish;
  endtask

  // Word index is address bits 11 to 3
  function automatic logic [8:0] word_index(input dram_soc_pkg::soc_addr_t addr);
    return addr[`DRAM_MEM_ADDR_WIDTH-1:3];
  endfunction

  function automatic dram_soc_pkg::soc_addr_t build_addr(input logic [19:0] upper,
                                                         input logic [8:0] idx,
                                                         input logic [2:0] off);
    return {upper, idx, off};
  endfunction

  function automatic void merge_shadow(input dram_soc_pkg::soc_addr_t addr,
                                       input dram_soc_pkg::soc_data_t data,
                                       input dram_soc_pkg::soc_strb_t strb);
    logic [8:0] idx;
    idx = word_index(addr);
    for (int byte_i = 0; byte_i < `DRAM_STRB_WIDTH; byte_i++)
      if (strb[byte_i])
        shadow[idx][8*byte_i +: 8] = data[8*byte_i +: 8];
  endfunction

  function automatic void start_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endfunction

  // Two spare cycles let the next-cycle checks finish first
  task automatic end_test();
    idle_cycles(2);
    tests_run++;
    if (errors == errors_at_start)
      $display("test %s: passed", test_name);
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  `include "tb_dram_tasks.svh"

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  quiet_after_reset: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    !req_sent |-> !soc_b_valid_o && !soc_r_valid_o)
    else log_violation("response valid raised before any request");

  b_id_restored: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    soc_b_valid_o |-> soc_b_id_o == exp_b_id)
    else log_mismatch("b id", 64'(exp_b_id), 64'($sampled(soc_b_id_o)));

  b_resp_okay: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    soc_b_valid_o |-> soc_b_resp_o == resp_okay_exp)
    else log_mismatch("b resp", 64'(resp_okay_exp), 64'($sampled(soc_b_resp_o)));

  b_held: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    soc_b_valid_o && !soc_b_ready_i |=>
      soc_b_valid_o && $stable(soc_b_id_o) && $stable(soc_b_resp_o))
    else log_violation("write response dropped or changed while stalled");

  b_matches_write: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    soc_b_valid_o && soc_b_ready_i |-> wr_open)
    else log_violation("write response delivered without an open write");

  b_single: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    soc_b_valid_o && soc_b_ready_i |=> !soc_b_valid_o)
    else log_violation("write response repeated after its handshake");

  aw_blocked: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    wr_open |-> !soc_aw_ready_o)
    else log_violation("aw ready high while a write is outstanding");

  w_blocked: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    w_cnt > b_cnt |-> !soc_w_ready_o)
    else log_violation("w ready high while write data is outstanding");

  r_id_restored: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    soc_r_valid_o |-> soc_r_id_o == exp_r_id)
    else log_mismatch("r id", 64'(exp_r_id), 64'($sampled(soc_r_id_o)));

  r_data_merged: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    soc_r_valid_o |-> soc_r_data_o == exp_r_data)
    else log_mismatch("r data", exp_r_data, $sampled(soc_r_data_o));

  r_resp_okay: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    soc_r_valid_o |-> soc_r_resp_o == resp_okay_exp)
    else log_mismatch("r resp", 64'(resp_okay_exp), 64'($sampled(soc_r_resp_o)));

  r_held: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    soc_r_valid_o && !soc_r_ready_i |=> soc_r_valid_o && $stable(soc_r_id_o) &&
      $stable(soc_r_data_o) && $stable(soc_r_resp_o))
    else log_violation("read data dropped or changed while stalled");

  r_matches_read: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    soc_r_valid_o && soc_r_ready_i |-> rd_open)
    else log_violation("read data delivered without an open read");

  r_single: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    soc_r_valid_o && soc_r_ready_i |=> !soc_r_valid_o)
    else log_violation("read data repeated after its handshake");

  ar_blocked: assert property (@(posedge soc_clk_i) disable iff (!arst_n_i)
    rd_open |-> !soc_ar_ready_o)
    else log_violation("ar ready high while a read is outstanding");

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial
  begin
    int                      k;
    int                      aw_target;
    int                      w_target;
    int                      ar_target;
    logic [8:0]              idx [8];
    logic [19:0]             upper;
    dram_soc_pkg::soc_addr_t addr_a;
    dram_soc_pkg::soc_addr_t addr_b;

    arst_n_i = 1'b0;
    soc_aw_valid_i = 1'b0;
    soc_aw_id_i = '0;
    soc_aw_addr_i = '0;
    soc_w_valid_i = 1'b0;
    soc_w_data_i = '0;
    soc_w_strb_i = '0;
    soc_b_ready_i = 1'b0;
    soc_ar_valid_i = 1'b0;
    soc_ar_id_i = '0;
    soc_ar_addr_i = '0;
    soc_r_ready_i = 1'b0;
    req_sent = 1'b0;
    exp_b_id = '0;
    exp_r_id = '0;
    exp_r_data = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    void'($urandom(45));
    for (int i = 0; i < `DRAM_MEM_WORDS; i++)
      shadow[i] = '0;

    // Reset low for two cycles, released on a falling edge
    repeat (2) @(posedge soc_clk_i);
    @(negedge soc_clk_i);
    arst_n_i = 1'b1;

    start_test("reset_state");
    idle_cycles(8);
    end_test();

    start_test("write_read");
    for (k = 0; k < 8; k++)
    begin
      idx[k] = 9'($urandom_range(0, 479));
      write_word(6'($urandom), build_addr(20'h0, idx[k], 3'h0), {$urandom, $urandom},
                 8'($urandom_range(1, 255)));
    end
    // Partial overwrite of a word already holding data
    write_word(6'($urandom), build_addr(20'h0, idx[0], 3'h4), {$urandom, $urandom}, 8'hA5);
    for (k = 0; k < 8; k++)
      read_word(6'($urandom), build_addr(20'h0, idx[k], 3'h0));
    read_word(6'($urandom), build_addr(20'h0, 9'd511, 3'h0));
    end_test();

    // Upper two ID bits vary, so narrowing alone would lose them
    start_test("id_restore");
    for (k = 0; k < 6; k++)
    begin
      write_word({2'(k + 1), 4'($urandom)}, build_addr(20'h0, 9'(480 + k), 3'h0),
                 {$urandom, $urandom}, 8'hFF);
      read_word({2'(k + 2), 4'($urandom)}, build_addr(20'h0, 9'(480 + k), 3'h0));
    end
    end_test();

    start_test("addr_alias");
    for (k = 0; k < 4; k++)
    begin
      upper = 20'($urandom);
      addr_a = build_addr(upper, 9'(490 + k), 3'h0);
      addr_b = build_addr(upper ^ 20'(k + 1), 9'(490 + k), 3'h0);
      write_word(6'($urandom), addr_a, {$urandom, $urandom}, 8'($urandom_range(1, 255)));
      read_word(6'($urandom), addr_b);
      write_word(6'($urandom), addr_b, {$urandom, $urandom}, 8'h3C);
      read_word(6'($urandom), addr_a);
    end
    end_test();

    // Held response, then an identical request waits behind it
    start_test("back_pressure");
    addr_a = build_addr(20'h5, 9'd77, 3'h0);
    aw_target = aw_cnt + 1;
    w_target = w_cnt + 1;
    drive_write(6'h2D, addr_a, 64'h0123_4567_89AB_CDEF, 8'hFF);
    wait_write_accept(aw_target, w_target);
    idle_cycles(12);
    soc_aw_valid_i = 1'b1;
    soc_w_valid_i = 1'b1;
    idle_cycles(8);
    collect_write_resp();
    wait_write_accept(aw_target + 1, w_target + 1);
    collect_write_resp();

    ar_target = ar_cnt + 1;
    drive_read(6'h3A, addr_a);
    wait_read_accept(ar_target);
    idle_cycles(12);
    soc_ar_valid_i = 1'b1;
    idle_cycles(8);
    collect_read_resp();
    wait_read_accept(ar_target + 1);
    collect_read_resp();
    end_test();

    $display("%0d tests run, %0d failed, %0d assertion errors", tests_run, tests_failed,
             errors);
    if (errors == 0)
    begin
      $display("Verification passed");
    end
    else
    begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+source
+incdir+testbench
source/dram_soc_pkg.sv
source/dram_mem_pkg.sv
source/dram_axi_if.sv
source/dram_port_adapter.sv
source/dram_spill_reg.sv
source/dram_mem_model.sv
source/dram_wrapper.sv
testbench/tb_dram_wrapper.sv

// ==== Bender.yml ====
package:
  name: dram_wrapper

sources:
  # Design, packages first
  - include_dirs:
      - source
    files:
      - source/dram_soc_pkg.sv
      - source/dram_mem_pkg.sv
      - source/dram_axi_if.sv
      - source/dram_port_adapter.sv
      - source/dram_spill_reg.sv
      - source/dram_mem_model.sv
      - source/dram_wrapper.sv

  # Testbench
  - target: test
    include_dirs:
      - source
      - testbench
    files:
      - testbench/tb_dram_wrapper.sv
